//--- common/uartDefines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

//////////////////////////////
// Register map
//////////////////////////////

`define UCR_ADDR 3'd0           // Control
`define USR_ADDR 3'd1           // Status, read clears interrupt flags
`define TDR_ADDR 3'd2           // Transmit data and FIFO clears
`define RDR_ADDR 3'd3           // Receive data and ready bits
`define SPR_ADDR 3'd4           // Scratch

// FIFO clear commands in a TDR write
`define TFC_BIT 11
`define RFC_BIT 10

// FIFO depth as address bits, 16 entries each
`define TX_FIFO_ABITS 4
`define RX_FIFO_ABITS 4

// Baud ticks per serial bit
`define OVERSAMPLE 16

`endif

//--- common/uartPkg.sv
`default_nettype none

package uartPkg;

    typedef logic [11:0] busWordT;  // Host register word
    typedef logic [2:0]  regAddrT;  // Register select
    typedef logic [7:0]  charT;     // Serial character
    typedef logic [8:0]  rxWordT;   // Error flag over character
    typedef logic [3:0]  fmtSelT;   // UCR format field
    typedef logic [3:0]  baudSelT;  // UCR baud field
    typedef logic [1:0]  modeT;     // UCR mode field
    typedef logic [1:0]  parSelT;   // Odd, even, space, mark
    typedef logic [3:0]  psT;       // Baud prescale reload
    typedef logic [7:0]  divT;      // Baud divide reload

    typedef enum logic [2:0] {
        txSIdle, txSStart, txSData, txSParity, txSStop
    } txStateT;

    typedef enum logic [2:0] {
        rxSIdle, rxSStart, rxSData, rxSParity, rxSStop
    } rxStateT;

    // Parity bit sent or expected for a character
    function automatic logic parityOf(input charT data, input parSelT sel);
        case (sel)
            2'b00:   return ~^data;     // Odd
            2'b01:   return ^data;      // Even
            2'b10:   return 1'b0;       // Space
            default: return 1'b1;       // Mark
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/syncFifo.sv
`default_nettype none

module syncFifo #(
    parameter int AddrBits = 4,
    parameter int Width    = 8
)(
    input  wire logic              SCK,
    input  wire logic              Rst,
    input  wire logic              clr,     // Synchronous flush
    input  wire logic              push,
    input  wire logic              pop,
    input  wire logic [Width-1:0]  din,
    output logic      [Width-1:0]  dout,    // Show-ahead head
    output logic                   full,
    output logic                   half,
    output logic                   empty,
    output logic      [AddrBits:0] count
);

    logic [Width-1:0]    mem [2**AddrBits];
    logic [AddrBits-1:0] wrPtr;
    logic [AddrBits-1:0] rdPtr;
    logic                doPush;
    logic                doPop;

    assign doPush = push & ~full;   // Dropped when full
    assign doPop  = pop & ~empty;   // Ignored when empty

    always_ff @(posedge SCK or posedge Rst)
    begin
        if (Rst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else if (clr)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
            if (doPush & ~doPop)
                count <= count + 1'b1;
            else if (doPop & ~doPush)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge SCK)
    begin
        if (doPush)
            mem[wrPtr] <= din;
    end

    assign dout  = mem[rdPtr];
    assign full  = count[AddrBits];
    assign half  = |count[AddrBits:AddrBits-1];    // At least half of depth
    assign empty = (count == '0);

endmodule

`default_nettype wire

//--- src/baudGen.sv
`default_nettype none

module baudGen
    import uartPkg::*;
(
    input  wire logic SCK,
    input  wire logic Rst,
    input  wire psT   ps,
    input  wire divT  div,
    output logic      tick16    // One cycle per 1/16 bit
);

    psT  psCnt;
    divT divCnt;

    always_ff @(posedge SCK or posedge Rst)
    begin
        if (Rst)
        begin
            psCnt  <= '0;
            divCnt <= '0;
            tick16 <= 1'b0;
        end
        else
        begin
            tick16 <= 1'b0;
            if (psCnt == '0)
            begin
                psCnt <= ps;                // Prescaler wrap steps the divider
                if (divCnt == '0)
                begin
                    divCnt <= div;
                    tick16 <= 1'b1;         // Both counters wrapped
                end
                else
                    divCnt <= divCnt - 1'b1;
            end
            else
                psCnt <= psCnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- serial/txEngine.sv
`default_nettype none
`include "uartDefines.svh"

module txEngine
    import uartPkg::*;
(
    input  wire logic   SCK,
    input  wire logic   Rst,
    input  wire logic   tick16,
    input  wire logic   len7,
    input  wire logic   stop2,
    input  wire logic   parEn,
    input  wire parSelT parSel,
    input  wire charT   txHead,
    input  wire logic   txEmpty,
    input  wire logic   ctsOk,
    output logic        txPop,
    output logic        txD,
    output logic        txIdle
);

    localparam logic [3:0] BitEnd = 4'(`OVERSAMPLE - 1);   // Last tick of a bit

    txStateT    state;
    logic [3:0] tickCnt;
    logic [2:0] bitCnt;
    logic       moreStop;       // Second stop bit pending
    charT       loadChar;
    charT       shReg;
    logic       parBit;

    assign loadChar = len7 ? {1'b0, txHead[6:0]} : txHead;
    assign txIdle   = (state == txSIdle);
    assign txPop    = txIdle & tick16 & ~txEmpty & ctsOk;   // Frame starts on a tick

    // Character and parity captured with the pop
    always_ff @(posedge SCK)
    begin
        if (txPop)
        begin
            shReg  <= loadChar;
            parBit <= parityOf(loadChar, parSel);
        end
    end

    always_ff @(posedge SCK or posedge Rst)
    begin
        if (Rst)
        begin
            state    <= txSIdle;
            tickCnt  <= '0;
            bitCnt   <= '0;
            moreStop <= 1'b0;
            txD      <= 1'b1;           // Mark
        end
        else if (txPop)
        begin
            state   <= txSStart;
            tickCnt <= '0;
            txD     <= 1'b0;            // Start bit
        end
        else if (tick16 && !txIdle)
        begin
            tickCnt <= tickCnt + 1'b1;
            if (tickCnt == BitEnd)
            begin
                case (state)
                    txSStart:
                    begin
                        state  <= txSData;
                        bitCnt <= '0;
                        txD    <= shReg[0];     // LSB first
                    end
                    txSData:
                    begin
                        bitCnt <= bitCnt + 1'b1;
                        txD    <= shReg[bitCnt + 3'd1];
                        if (bitCnt == (len7 ? 3'd6 : 3'd7))
                        begin
                            state    <= parEn ? txSParity : txSStop;
                            txD      <= parEn ? parBit : 1'b1;
                            moreStop <= stop2;
                        end
                    end
                    txSParity:
                    begin
                        state <= txSStop;
                        txD   <= 1'b1;
                    end
                    default:
                    begin
                        moreStop <= 1'b0;
                        if (!moreStop)
                            state <= txSIdle;   // Frame done
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- serial/rxEngine.sv
`default_nettype none
`include "uartDefines.svh"

module rxEngine
    import uartPkg::*;
(
    input  wire logic   SCK,
    input  wire logic   Rst,
    input  wire logic   tick16,
    input  wire logic   len7,
    input  wire logic   stop2,
    input  wire logic   parEn,
    input  wire parSelT parSel,
    input  wire logic   rxD,
    output logic        rxPush,
    output rxWordT      rxWord,
    output logic        rxIdle
);

    localparam logic [3:0] MidBit = 4'(`OVERSAMPLE / 2 - 1);

    rxStateT    state;
    logic [2:0] rxPipe;         // Two sync stages plus edge history
    logic       rxIn;
    logic       rxFall;
    logic       sample;
    logic [3:0] tickCnt;
    logic [2:0] bitCnt;
    logic       moreStop;
    logic       rxErr;          // Parity or framing error so far
    charT       shReg;

    always_ff @(posedge SCK or posedge Rst)
    begin
        if (Rst)
            rxPipe <= '1;       // Mark
        else
            rxPipe <= {rxPipe[1:0], rxD};
    end

    assign rxIn   = rxPipe[1];
    assign rxFall = rxPipe[2] & ~rxPipe[1];
    assign rxIdle = (state == rxSIdle);
    assign sample = tick16 & ~rxIdle & (tickCnt == MidBit);     // Mid-bit

    // Data bits and FIFO word
    always_ff @(posedge SCK)
    begin
        if (rxIdle)
            shReg <= '0;        // Bit 7 stays 0 in 7-bit frames
        else if (sample && state == rxSData)
            shReg[bitCnt] <= rxIn;
        if (sample && state == rxSStop && !moreStop)
            rxWord <= {rxErr | ~rxIn, shReg};
    end

    always_ff @(posedge SCK or posedge Rst)
    begin
        if (Rst)
        begin
            state    <= rxSIdle;
            tickCnt  <= '0;
            bitCnt   <= '0;
            moreStop <= 1'b0;
            rxErr    <= 1'b0;
            rxPush   <= 1'b0;
        end
        else
        begin
            rxPush <= 1'b0;
            if (rxIdle)
            begin
                tickCnt <= '0;
                rxErr   <= 1'b0;
                if (rxFall)
                    state <= rxSStart;
            end
            else if (tick16)
            begin
                tickCnt <= tickCnt + 1'b1;
                if (tickCnt == MidBit)
                begin
                    case (state)
                        rxSStart:
                        begin
                            state  <= rxIn ? rxSIdle : rxSData;  // Glitch rejected
                            bitCnt <= '0;
                        end
                        rxSData:
                        begin
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt == (len7 ? 3'd6 : 3'd7))
                            begin
                                state    <= parEn ? rxSParity : rxSStop;
                                moreStop <= stop2;
                            end
                        end
                        rxSParity:
                        begin
                            state <= rxSStop;
                            if (rxIn != parityOf(shReg, parSel))
                                rxErr <= 1'b1;
                        end
                        default:
                        begin
                            moreStop <= 1'b0;
                            if (!rxIn)
                                rxErr <= 1'b1;  // Low stop bit
                            if (!moreStop)
                            begin
                                state  <= rxSIdle;
                                rxPush <= 1'b1;
                            end
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/uartRegs.sv
`default_nettype none
`include "uartDefines.svh"

module uartRegs
    import uartPkg::*;
(
    input  wire logic    SCK,
    input  wire logic    Rst,
    // Wishbone classic slave
    input  wire logic    wbCyc,
    input  wire logic    wbStb,
    input  wire logic    wbWe,
    input  wire regAddrT wbAdr,
    input  wire busWordT wbDatI,
    output busWordT      wbDatO,
    output logic         wbAck,
    // Transmit FIFO
    input  wire logic    txFull,
    input  wire logic    txHalf,
    input  wire logic    txEmpty,
    input  wire logic    txIdle,
    output logic         txPush,
    output charT         txData,
    output logic         txClr,
    // Receive FIFO
    input  wire logic    rxFull,
    input  wire logic    rxHalf,
    input  wire logic    rxEmpty,
    input  wire rxWordT  rxHead,
    output logic         rxPop,
    output logic         rxClr,
    // Frame format and baud
    output logic         len7,
    output logic         stop2,
    output logic         parEn,
    output parSelT       parSel,
    output psT           ps,
    output divT          div,
    // Handshake and interrupt
    input  wire logic    cts,
    output logic         ctsOk,
    output logic         rts,
    output logic         irq
);

    regAddrT    reqAdr;         // Latched with the request
    logic       reqWe;
    busWordT    reqDat;
    logic       wrAck;
    logic       rdAck;
    logic       tdrWr;
    logic       usrRd;
    busWordT    ucr;
    busWordT    spr;
    charT       tdr;            // Last byte written, read back at TDR
    modeT       mode;
    fmtSelT     fmt;
    baudSelT    baud;
    logic       rtsO;
    logic       ie;
    logic [1:0] rs;
    logic [1:0] ts;
    logic [2:0] intCond;        // {rda, the, tfe} conditions
    logic [2:0] intCondQ;
    logic [2:0] intFlags;       // {iRDA, iTHE, iTFE}

    //////////////////////////////
    // Wishbone handshake
    //////////////////////////////

    always_ff @(posedge SCK or posedge Rst)
    begin
        if (Rst)
        begin
            wbAck  <= 1'b0;
            reqAdr <= '0;
            reqWe  <= 1'b0;
        end
        else
        begin
            wbAck <= wbCyc & wbStb & ~wbAck;    // Single ack, then drop
            if (wbCyc & wbStb & ~wbAck)
            begin
                reqAdr <= wbAdr;
                reqWe  <= wbWe;
            end
        end
    end

    always_ff @(posedge SCK)
    begin
        if (wbCyc & wbStb & ~wbAck)
            reqDat <= wbDatI;
    end

    // Side effects all land at the end of the ack cycle
    assign wrAck  = wbAck & reqWe;
    assign rdAck  = wbAck & ~reqWe;
    assign tdrWr  = wrAck & (reqAdr == `TDR_ADDR);
    assign usrRd  = rdAck & (reqAdr == `USR_ADDR);
    assign txClr  = tdrWr & reqDat[`TFC_BIT];
    assign rxClr  = tdrWr & reqDat[`RFC_BIT];
    assign txPush = tdrWr & ~txClr & ~rxClr;   // Clear command carries no byte
    assign txData = reqDat[7:0];
    assign rxPop  = rdAck & (reqAdr == `RDR_ADDR) & ~rxEmpty;  // Stale head if empty

    always_ff @(posedge SCK or posedge Rst)
    begin
        if (Rst)
        begin
            ucr <= '0;
            spr <= '0;
            tdr <= '0;
        end
        else if (wrAck)
        begin
            case (reqAdr)
                `UCR_ADDR: ucr <= reqDat;
                `TDR_ADDR: tdr <= reqDat[7:0];
                `SPR_ADDR: spr <= reqDat;
                default:   ;
            endcase
        end
    end

    // UCR fields
    assign mode = ucr[11:10];
    assign rtsO = ucr[9];
    assign ie   = ucr[8];
    assign fmt  = ucr[7:4];
    assign baud = ucr[3:0];

    //////////////////////////////
    // Format and baud tables
    //////////////////////////////

    always_comb
    begin
        case (fmt)      // {len7, stop2, parEn, parSel}
            4'h2:    {len7, stop2, parEn, parSel} = 5'b0_0_1_00;    // 8O1
            4'h3:    {len7, stop2, parEn, parSel} = 5'b0_0_1_01;    // 8E1
            4'h4:    {len7, stop2, parEn, parSel} = 5'b0_0_1_10;    // 8S1
            4'h5:    {len7, stop2, parEn, parSel} = 5'b0_0_1_11;    // 8M1
            4'h7:    {len7, stop2, parEn, parSel} = 5'b0_1_0_00;    // 8N2
            4'h8:    {len7, stop2, parEn, parSel} = 5'b0_1_1_00;    // 8O2
            4'h9:    {len7, stop2, parEn, parSel} = 5'b0_1_1_01;    // 8E2
            4'hA:    {len7, stop2, parEn, parSel} = 5'b0_1_1_10;    // 8S2
            4'hB:    {len7, stop2, parEn, parSel} = 5'b0_1_1_11;    // 8M2
            4'hC:    {len7, stop2, parEn, parSel} = 5'b1_0_1_00;    // 7O1
            4'hD:    {len7, stop2, parEn, parSel} = 5'b1_0_1_01;    // 7E1
            4'hE:    {len7, stop2, parEn, parSel} = 5'b1_1_1_00;    // 7O2
            4'hF:    {len7, stop2, parEn, parSel} = 5'b1_1_1_01;    // 7E2
            default: {len7, stop2, parEn, parSel} = 5'b0_0_0_00;    // 8N1, codes 0 1 6
        endcase
    end

    // Tick period is (ps+1)*(div+1) clocks, 16 ticks per bit
    always_comb
    begin
        case (baud)
            4'h0:    {ps, div} = {4'h0, 8'h01};
            4'h1:    {ps, div} = {4'h0, 8'h02};
            4'h2:    {ps, div} = {4'h0, 8'h05};
            4'h3:    {ps, div} = {4'h0, 8'h0F};
            4'h4:    {ps, div} = {4'hC, 8'h00};
            4'h5:    {ps, div} = {4'hC, 8'h01};
            4'h6:    {ps, div} = {4'hC, 8'h02};
            4'h7:    {ps, div} = {4'hC, 8'h03};
            4'h8:    {ps, div} = {4'hC, 8'h05};
            4'h9:    {ps, div} = {4'hC, 8'h07};
            4'hA:    {ps, div} = {4'hC, 8'h0B};
            4'hB:    {ps, div} = {4'hC, 8'h0F};
            4'hC:    {ps, div} = {4'hC, 8'h17};
            4'hD:    {ps, div} = {4'hC, 8'h2F};
            4'hE:    {ps, div} = {4'hC, 8'h5F};
            default: {ps, div} = {4'hC, 8'hBF};
        endcase
    end

    //////////////////////////////
    // Status, handshake, IRQ
    //////////////////////////////

    // 0 empty, 1 below half, 2 at or above half, 3 full
    assign rs = rxFull ? 2'd3 : rxHalf ? 2'd2 : rxEmpty ? 2'd0 : 2'd1;
    assign ts = txFull ? 2'd3 : txHalf ? 2'd2 : (txEmpty & txIdle) ? 2'd0 : 2'd1;

    // Mode 1 is auto handshake, every other mode behaves as mode 0
    assign rts   = (mode == 2'd1) ? ~rxHalf : rtsO;
    assign ctsOk = (mode == 2'd1) ? cts : 1'b1;

    assign intCond = {rxHalf, ~txHalf, txEmpty & txIdle};

    // Flags set on a rising condition only
    always_ff @(posedge SCK or posedge Rst)
    begin
        if (Rst)
        begin
            intCondQ <= 3'b011;     // Matches the idle conditions
            intFlags <= '0;
        end
        else
        begin
            intCondQ <= intCond;
            if (usrRd)
                intFlags <= '0;
            else
                intFlags <= intFlags | (intCond & ~intCondQ);
        end
    end

    assign irq = ie & (|intFlags);

    always_comb
    begin
        case (reqAdr)
            `UCR_ADDR: wbDatO = ucr;
            `USR_ADDR: wbDatO = {mode, rts, ctsOk, rs, ts, 1'b0, intFlags};
            `TDR_ADDR: wbDatO = {4'h0, tdr};
            `RDR_ADDR: wbDatO = {~txFull, ~rxEmpty, 1'b0, rxHead};  // RTO reads 0
            `SPR_ADDR: wbDatO = spr;
            default:   wbDatO = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/sspUart.sv
`default_nettype none
`include "uartDefines.svh"

module sspUart
    import uartPkg::*;
(
    input  wire logic    SCK,
    input  wire logic    Rst,
    // Wishbone classic slave
    input  wire logic    wbCyc,
    input  wire logic    wbStb,
    input  wire logic    wbWe,
    input  wire regAddrT wbAdr,
    input  wire busWordT wbDatI,
    output wire busWordT wbDatO,
    output wire logic    wbAck,
    // Serial side
    input  wire logic    rxD,
    input  wire logic    cts,
    output wire logic    txD,
    output wire logic    rts,
    output wire logic    irq,
    output wire logic    txIdle,
    output wire logic    rxIdle
);

    // Transmit path
    logic   txPush;
    charT   txData;
    logic   txClr;
    logic   txPop;
    charT   txHead;
    logic   txFull;
    logic   txHalf;
    logic   txEmpty;
    // Receive path
    logic   rxPush;
    rxWordT rxWord;
    logic   rxPop;
    logic   rxClr;
    rxWordT rxHead;
    logic   rxFull;
    logic   rxHalf;
    logic   rxEmpty;
    // Frame, baud, handshake
    logic   len7;
    logic   stop2;
    logic   parEn;
    parSelT parSel;
    psT     ps;
    divT    div;
    logic   ctsOk;
    logic   tick16;

    //////////////////////////////
    // Registers and baud clock
    //////////////////////////////

    uartRegs u_uartRegs (.*);

    baudGen u_baudGen (.*);

    //////////////////////////////
    // Holding FIFOs
    //////////////////////////////

    syncFifo #(
        .AddrBits (`TX_FIFO_ABITS),
        .Width    (8)
    ) u_txFifo (
        .SCK   (SCK),
        .Rst   (Rst),
        .clr   (txClr),
        .push  (txPush),
        .pop   (txPop),
        .din   (txData),
        .dout  (txHead),
        .full  (txFull),
        .half  (txHalf),
        .empty (txEmpty),
        .count ()
    );

    syncFifo #(
        .AddrBits (`RX_FIFO_ABITS),
        .Width    (9)           // Error flag over character
    ) u_rxFifo (
        .SCK   (SCK),
        .Rst   (Rst),
        .clr   (rxClr),
        .push  (rxPush),
        .pop   (rxPop),
        .din   (rxWord),
        .dout  (rxHead),
        .full  (rxFull),
        .half  (rxHalf),
        .empty (rxEmpty),
        .count ()
    );

    //////////////////////////////
    // Serial engines
    //////////////////////////////

    txEngine u_txEngine (.*);

    rxEngine u_rxEngine (.*);

endmodule

`default_nettype wire

//--- test/uartTb.sv
`default_nettype none
`include "uartDefines.svh"

module uartTb
    import uartPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int      BitClocks   = 32;              // Baud 0, tick every 2 clocks
    localparam int      FrameClocks = 12 * BitClocks;  // Longest frame, parity and 2 stop
    localparam int      FrameCount  = 22;              // Frames sent over all tests
    localparam int      SlowTick    = 13 * 192;        // Slowest baud tick, settles after test 2
    localparam int      CycleLimit  = 2 * ((FrameCount + 2) * FrameClocks + SlowTick);
    localparam int      WaitLimit   = 20 * FrameClocks;
    localparam int      QuietClocks = 2 * BitClocks;   // Line idle this long means done
    localparam int      AckLimit    = 8;
    localparam int      FifoDepth   = 2 ** `RX_FIFO_ABITS;
    localparam int      RrdyBit     = 10;
    localparam busWordT RxClear     = 12'd1 << `RFC_BIT;
    localparam busWordT UcrMode1    = 12'h400;         // MD = 1, auto handshake
    localparam busWordT UcrIe       = 12'h100;

    logic    SCK;
    logic    Rst;
    logic    wbCyc;
    logic    wbStb;
    logic    wbWe;
    regAddrT wbAdr;
    busWordT wbDatI;
    busWordT wbDatO;
    logic    wbAck;
    logic    cts;
    logic    txD;
    logic    rts;
    logic    irq;
    logic    txIdle;
    logic    rxIdle;

    string   testName;
    int      passCnt;
    int      failCnt;
    int      failAtStart;
    int      cycleCnt;
    string   nameQ[$];         // Pending checks for the comparing process
    busWordT expQ[$];
    busWordT actQ[$];
    charT    sent[$];          // Bytes in flight through the loopback

    sspUart u_sspUart (
        .SCK    (SCK),
        .Rst    (Rst),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatI (wbDatI),
        .wbDatO (wbDatO),
        .wbAck  (wbAck),
        .rxD    (txD),         // Loopback
        .cts    (cts),
        .txD    (txD),
        .rts    (rts),
        .irq    (irq),
        .txIdle (txIdle),
        .rxIdle (rxIdle)
    );

    initial SCK = 1'b0;
    always #10 SCK = ~SCK;

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    // FIFO level code, 0 empty 1 below half 2 half or more 3 full
    function automatic logic [1:0] levelCode(input int count, input int depth,
                                             input logic busy);
        if (count >= depth)
            return 2'd3;
        if (count >= depth / 2)
            return 2'd2;
        if (count == 0 && !busy)
            return 2'd0;        // Transmit side counts as empty only when idle
        return 2'd1;
    endfunction

    function automatic busWordT usrExpect(input logic [1:0] mode, input logic rtsV,
                                          input logic ctsOkV, input logic [1:0] rs,
                                          input logic [1:0] ts, input logic [2:0] flags);
        return {mode, rtsV, ctsOkV, rs, ts, 1'b0, flags};   // RTO always 0
    endfunction

    function automatic busWordT rdrExpect(input charT data, input fmtSelT fmt);
        charT expData;
        expData = (fmt >= 4'hC) ? {1'b0, data[6:0]} : data;   // Codes C..F are 7 bit
        return {1'b1, 1'b1, 1'b0, 1'b0, expData};             // TRDY RRDY RTO RERR
    endfunction

    // Compares everything queued since the last edge
    always @(posedge SCK)
    begin
        while (expQ.size() > 0)
        begin
            if (actQ[0] !== expQ[0])
            begin
                $display("FAIL %s expected %h actual %h", nameQ[0], expQ[0], actQ[0]);
                failCnt++;
            end
            else
                passCnt++;
            nameQ.delete(0);
            expQ.delete(0);
            actQ.delete(0);
        end
    end

    ////////////////////////////////
    // Helper tasks
    ////////////////////////////////

    task automatic queueCheck(input string what, input busWordT expV, input busWordT actV);
        nameQ.push_back({testName, ": ", what});
        expQ.push_back(expV);
        actQ.push_back(actV);
    endtask

    task automatic checkBit(input string what, input logic expV, input logic actV);
        queueCheck(what, {11'b0, expV}, {11'b0, actV});
    endtask

    task automatic reportProblem(input string msg);
        $display("ERROR %s: %s", testName, msg);
        failCnt++;
    endtask

    task automatic busAccess(input logic we, input regAddrT adr, input busWordT dat,
                             output busWordT rd);
        int waited;
        waited = 0;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatI = dat;
        @(negedge SCK);
        while (!wbAck && waited < AckLimit)
        begin
            @(negedge SCK);
            waited++;
        end
        rd    = wbDatO;         // Valid for the whole ack cycle
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        if (!wbAck)
            reportProblem($sformatf("no acknowledge for access to address %0d", adr));
    endtask

    task automatic busWrite(input regAddrT adr, input busWordT dat);
        busWordT unused;
        busAccess(1'b1, adr, dat, unused);
    endtask

    task automatic busRead(input regAddrT adr, output busWordT rd);
        busAccess(1'b0, adr, 12'h000, rd);
    endtask

    task automatic sendRandom(input int n);
        charT data;
        for (int i = 0; i < n; i++)
        begin
            data = 8'($urandom());
            sent.push_back(data);
            busWrite(`TDR_ADDR, {4'h0, data});
        end
    endtask

    // Start of the first frame, then a quiet line
    task automatic waitTransfer();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (txIdle && waited < WaitLimit)
        begin
            @(negedge SCK);
            waited++;
        end
        if (txIdle)
            reportProblem("transmitter never started");
        while (quiet < QuietClocks && waited < WaitLimit)
        begin
            @(negedge SCK);
            waited++;
            quiet = (txIdle && rxIdle) ? quiet + 1 : 0;
        end
        if (quiet < QuietClocks)
            reportProblem("serial line did not go idle");
    endtask

    task automatic checkReceived(input fmtSelT fmt);
        busWordT rd;
        int      idx;
        idx = 0;
        while (sent.size() > 0)
        begin
            busRead(`RDR_ADDR, rd);
            queueCheck($sformatf("fmt %h RDR word %0d", fmt, idx), rdrExpect(sent[0], fmt), rd);
            sent.delete(0);
            idx++;
        end
    endtask

    task automatic startTest(input string name);
        testName    = name;
        failAtStart = failCnt;
    endtask

    task automatic finishTest();
        @(posedge SCK);         // Let the comparer drain
        @(negedge SCK);
        $display("Test %-20s %s", testName, (failCnt == failAtStart) ? "passed" : "failed");
    endtask

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////

    initial
    begin
        busWordT rd;
        busWordT val;
        int      waited;
        fmtSelT  fmtList [3];
        fmtList  = '{4'h3, 4'h8, 4'hC};     // 8E1, 8O2, 7O1
        void'($urandom(32'h6077));
        passCnt  = 0;
        failCnt  = 0;
        Rst      = 1'b1;
        wbCyc    = 1'b0;
        wbStb    = 1'b0;
        wbWe     = 1'b0;
        wbAdr    = 3'd0;
        wbDatI   = 12'h000;
        cts      = 1'b1;
        repeat (3) @(posedge SCK);
        @(negedge SCK);
        Rst = 1'b0;

        startTest("reset state");
        busRead(`UCR_ADDR, rd);
        queueCheck("UCR", 12'h000, rd);
        busRead(`TDR_ADDR, rd);
        queueCheck("TDR", 12'h000, rd);
        busRead(`SPR_ADDR, rd);
        queueCheck("SPR", 12'h000, rd);
        busRead(`USR_ADDR, rd);
        queueCheck("USR", usrExpect(2'd0, 1'b0, 1'b1, levelCode(0, FifoDepth, 1'b0),
                   levelCode(0, FifoDepth, 1'b0), 3'b000), rd);
        checkBit("irq", 1'b0, irq);
        checkBit("rts", 1'b0, rts);
        checkBit("txD", 1'b1, txD);
        checkBit("txIdle", 1'b1, txIdle);
        checkBit("rxIdle", 1'b1, rxIdle);
        finishTest();

        startTest("register round trip");
        for (int i = 0; i < 4; i++)
        begin
            val = 12'($urandom());
            busWrite(`UCR_ADDR, val);
            busRead(`UCR_ADDR, rd);
            queueCheck($sformatf("UCR pass %0d", i), val, rd);
            val = 12'($urandom());
            busWrite(`SPR_ADDR, val);
            busRead(`SPR_ADDR, rd);
            queueCheck($sformatf("SPR pass %0d", i), val, rd);
        end
        busWrite(`UCR_ADDR, 12'h000);   // Mode 0, 8N1, baud 0
        finishTest();

        startTest("8N1 loopback");
        sendRandom(4);
        waitTransfer();
        checkReceived(4'h0);
        sendRandom(2);
        waitTransfer();
        busWrite(`TDR_ADDR, RxClear);
        sent.delete();
        busRead(`RDR_ADDR, rd);
        checkBit("RRDY after receive clear", 1'b0, rd[RrdyBit]);
        finishTest();

        startTest("parity formats");
        for (int f = 0; f < 3; f++)
        begin
            busWrite(`UCR_ADDR, {4'h0, fmtList[f], 4'h0});
            sendRandom(2);
            waitTransfer();
            checkReceived(fmtList[f]);
        end
        busWrite(`UCR_ADDR, 12'h000);
        finishTest();

        startTest("handshake mode 1");
        cts = 1'b0;
        busWrite(`UCR_ADDR, UcrMode1);
        sendRandom(1);
        repeat (2 * FrameClocks) @(negedge SCK);   // Transmitter held off by CTS
        busRead(`RDR_ADDR, rd);
        checkBit("RRDY while CTS low", 1'b0, rd[RrdyBit]);
        checkBit("RTS with empty receive FIFO", 1'b1, rts);
        cts = 1'b1;
        waitTransfer();
        checkReceived(4'h0);
        sendRandom(7);
        waitTransfer();
        checkBit("RTS with 7 words held", 1'b1, rts);
        sendRandom(1);
        waitTransfer();
        checkBit("RTS with 8 words held", 1'b0, rts);
        busWrite(`TDR_ADDR, RxClear);
        sent.delete();
        @(negedge SCK);
        checkBit("RTS after receive clear", 1'b1, rts);
        busWrite(`UCR_ADDR, 12'h000);
        finishTest();

        startTest("interrupts");
        busWrite(`UCR_ADDR, UcrIe);
        busRead(`USR_ADDR, rd);         // Drops flags left by earlier tests
        @(negedge SCK);
        checkBit("IRQ before send", 1'b0, irq);
        sendRandom(1);
        waited = 0;
        while (!irq && waited < WaitLimit)
        begin
            @(negedge SCK);
            waited++;
        end
        if (!irq)
            reportProblem("IRQ never rose after the transmitter emptied");
        checkBit("transmitter idle at IRQ", 1'b1, txIdle);
        busRead(`USR_ADDR, rd);
        queueCheck("USR with iTFE", usrExpect(2'd0, 1'b0, 1'b1, levelCode(1, FifoDepth, 1'b0),
                   levelCode(0, FifoDepth, 1'b0), 3'b001), rd);
        @(negedge SCK);
        checkBit("IRQ after USR read", 1'b0, irq);
        checkReceived(4'h0);
        busWrite(`UCR_ADDR, 12'h000);
        finishTest();

        $display("Checks passed %0d, failed %0d", passCnt, failCnt);
        if (failCnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // Run limit from the frame budget
    initial
    begin
        cycleCnt = 0;
        while (cycleCnt < CycleLimit)
        begin
            @(posedge SCK);
            cycleCnt++;
        end
        $display("Run stopped after %0d cycles, a test did not finish", cycleCnt);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/uartPkg.sv
src/syncFifo.sv
src/baudGen.sv
serial/txEngine.sv
serial/rxEngine.sv
src/uartRegs.sv
src/sspUart.sv
test/uartTb.sv

//--- run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    -f files.f --top-module uartTb -Mdir obj_dir -o uartSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/uartSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
exit 1
